/* src/mem_config.svh */
// data memory and load/store bus address widths, LED register address
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// byte address width of the data memory, 4 KiB.
`define DMEM_ADDR_WIDTH 12

// width of the load/store port address.
`define BUS_ADDR_WIDTH 16

// the LED register sits in the upper half of the bus address space.
`define LED_ADDR 16'h8000

`endif

/* src/mem_pkg.sv */
// mem_pkg: access width and bus target enumerations
`default_nettype none

package mem_pkg;

  // any width other than BYTE, HALFWORD or WORD stores nothing.
  typedef enum logic [1:0] {
    BYTE,
    HALFWORD,
    WORD,
    RESERVED
  } mem_width_t;

  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_DMEM,
    TGT_LED
  } mem_target_t;

endpackage

`default_nettype wire

/* src/spram_block.sv */
// spram_block: byte-wide single-port RAM with synchronous read-first port
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module spram_block (
  input  logic                         clk,
  input  logic [`DMEM_ADDR_WIDTH-3:0]  address,
  input  logic                         write_enable,
  input  logic [7:0]                   data_in,
  output logic [7:0]                   data_out
);

  logic [7:0] mem [2**(`DMEM_ADDR_WIDTH-2)];

  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[address] <= data_in;
    end
    data_out <= mem[address]; // old contents come out, the read is read-first.
  end

endmodule

`default_nettype wire

/* src/d_mem_spram.sv */
// d_mem_spram: byte-lane data memory over four lane RAMs with load extension
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module d_mem_spram
  import mem_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  mem_width_t                   width,
  input  logic                         sign_extend,
  input  logic [`DMEM_ADDR_WIDTH-1:0]  addr,
  input  logic [31:0]                  data_in,
  input  logic                         write_enable,
  output logic [31:0]                  data_out
);

  logic [1:0]                  offset;
  logic [`DMEM_ADDR_WIDTH-3:0] word_idx;
  logic [3:0]                  size_mask;
  logic [`DMEM_ADDR_WIDTH-3:0] lane_row [4];
  logic [3:0][7:0]             lane_din;
  logic [3:0][7:0]             lane_dout;
  logic [3:0]                  lane_we;
  logic [1:0]                  offset_q;
  mem_width_t                  width_q;
  logic                        sign_extend_q;
  logic [31:0]                 load_word;

  assign offset   = addr[1:0];
  assign word_idx = addr[`DMEM_ADDR_WIDTH-1:2];

  // bytes covered by the access, counted from the start address.
  always_comb begin
    case (width)
      BYTE:     size_mask = 4'b0001;
      HALFWORD: size_mask = 4'b0011;
      WORD:     size_mask = 4'b1111;
      default:  size_mask = 4'b0000;
    endcase
  end

  // lane n carries byte (n - offset) of the access.
  always_comb begin
    logic [1:0] k;
    logic       next_row;
    for (int n = 0; n < 4; n++) begin
      k = 2'(n) - offset;
      next_row = (2'(n) < offset); // lanes below the offset spill into the next row.
      lane_row[n] = word_idx + {{(`DMEM_ADDR_WIDTH-3){1'b0}}, next_row};
      lane_din[n] = data_in[8*k +: 8];
      lane_we[n]  = write_enable & size_mask[k];
    end
  end

  spram_block block_0 (
    .clk          (clk),
    .address      (lane_row[0]),
    .write_enable (lane_we[0]),
    .data_in      (lane_din[0]),
    .data_out     (lane_dout[0])
  );

  spram_block block_1 (
    .clk          (clk),
    .address      (lane_row[1]),
    .write_enable (lane_we[1]),
    .data_in      (lane_din[1]),
    .data_out     (lane_dout[1])
  );

  spram_block block_2 (
    .clk          (clk),
    .address      (lane_row[2]),
    .write_enable (lane_we[2]),
    .data_in      (lane_din[2]),
    .data_out     (lane_dout[2])
  );

  spram_block block_3 (
    .clk          (clk),
    .address      (lane_row[3]),
    .write_enable (lane_we[3]),
    .data_in      (lane_din[3]),
    .data_out     (lane_dout[3])
  );

  // the lane outputs arrive a cycle late, so the access shape follows them.
  always_ff @(posedge clk) begin
    if (reset) begin
      offset_q      <= 2'd0;
      width_q       <= RESERVED;
      sign_extend_q <= 1'b0;
    end else begin
      offset_q      <= offset;
      width_q       <= width;
      sign_extend_q <= sign_extend;
    end
  end

  always_comb begin
    logic [1:0] src;
    for (int k = 0; k < 4; k++) begin
      src = 2'(k) + offset_q;
      load_word[8*k +: 8] = lane_dout[src]; // little-endian from the start address.
    end
    case (width_q)
      BYTE:     data_out = {{24{sign_extend_q & load_word[7]}}, load_word[7:0]};
      HALFWORD: data_out = {{16{sign_extend_q & load_word[15]}}, load_word[15:0]};
      default:  data_out = load_word;
    endcase
  end

endmodule

`default_nettype wire

/* src/led_port.sv */
// led_port: memory-mapped LED register with word writes and read-back
`timescale 1ns/10ps
`default_nettype none

module led_port
  import mem_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  mem_width_t  width,
  input  logic [31:0] data_in,
  input  logic        write_enable,
  output logic [31:0] data_out,
  output logic [3:0]  leds
);

  logic [31:0] led_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      led_reg <= 32'd0;
    end else if (write_enable && width == WORD) begin
      led_reg <= data_in; // narrower stores are dropped.
    end
  end

  // read-back samples the register before a same-cycle store, like the RAMs.
  always_ff @(posedge clk) begin
    data_out <= led_reg;
  end

  assign leds = led_reg[3:0];

endmodule

`default_nettype wire

/* src/mem_bus_decode.sv */
// mem_bus_decode: load/store address decoder and read data select
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module mem_bus_decode
  import mem_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`BUS_ADDR_WIDTH-1:0]  addr,
  input  logic                        write_enable,
  input  logic [31:0]                 dmem_data_out,
  input  logic [31:0]                 led_data_out,
  output logic                        dmem_write_enable,
  output logic                        led_write_enable,
  output logic [31:0]                 data_out
);

  mem_target_t target;
  mem_target_t target_q;

  always_comb begin
    if (!addr[`BUS_ADDR_WIDTH-1]) begin
      target = TGT_DMEM; // the low half aliases onto the data memory.
    end else if (addr == `LED_ADDR) begin
      target = TGT_LED;
    end else begin
      target = TGT_NONE;
    end
  end

  assign dmem_write_enable = write_enable && (target == TGT_DMEM);
  assign led_write_enable  = write_enable && (target == TGT_LED);

  always_ff @(posedge clk) begin
    if (reset) begin
      target_q <= TGT_NONE;
    end else begin
      target_q <= target;
    end
  end

  always_comb begin
    case (target_q)
      TGT_DMEM: data_out = dmem_data_out;
      TGT_LED:  data_out = led_data_out;
      default:  data_out = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

/* src/arty_mem_top.sv */
// arty_mem_top: decoder, data memory and LED port on one load/store port
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module arty_mem_top
  import mem_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`BUS_ADDR_WIDTH-1:0]  addr,
  input  mem_width_t                  width,
  input  logic                        sign_extend,
  input  logic [31:0]                 data_in,
  input  logic                        write_enable,
  output logic [31:0]                 data_out,
  output logic [3:0]                  leds
);

  logic        dmem_write_enable;
  logic        led_write_enable;
  logic [31:0] dmem_data_out;
  logic [31:0] led_data_out;

  mem_bus_decode i_mem_bus_decode (
    .clk               (clk),
    .reset             (reset),
    .addr              (addr),
    .write_enable      (write_enable),
    .dmem_data_out     (dmem_data_out),
    .led_data_out      (led_data_out),
    .dmem_write_enable (dmem_write_enable),
    .led_write_enable  (led_write_enable),
    .data_out          (data_out)
  );

  d_mem_spram i_d_mem_spram (
    .clk          (clk),
    .reset        (reset),
    .width        (width),
    .sign_extend  (sign_extend),
    .addr         (addr[`DMEM_ADDR_WIDTH-1:0]),
    .data_in      (data_in),
    .write_enable (dmem_write_enable),
    .data_out     (dmem_data_out)
  );

  led_port i_led_port (
    .clk          (clk),
    .reset        (reset),
    .width        (width),
    .data_in      (data_in),
    .write_enable (led_write_enable),
    .data_out     (led_data_out),
    .leds         (leds)
  );

endmodule

`default_nettype wire

/* verification/arty_mem_asserts.sv */
// arty_mem_asserts: write enable, lane enable and unmapped read assertions with their binds
`timescale 1ns/10ps
`default_nettype none

module arty_mem_asserts
  import mem_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input logic        write_enable,
  input logic [3:0]  lane_we,
  input logic        dmem_write_enable,
  input logic        led_write_enable,
  input mem_target_t target,
  input logic [31:0] data_out
);

  int failures = 0;

  one_write_target: assert property (@(posedge clk) disable iff (reset)
    !(dmem_write_enable && led_write_enable))
    else begin
      failures++;
      $error("memory and LED write enables are high together");
    end
  lanes_gated: assert property (@(posedge clk) disable iff (reset)
    !write_enable |-> lane_we == 4'b0000)
    else begin
      failures++;
      $error("a lane write enable is high without write_enable");
    end
  unmapped_reads_zero: assert property (@(posedge clk) disable iff (reset)
    target == TGT_NONE |=> data_out == 32'd0)
    else begin
      failures++;
      $error("data_out is not zero after an unmapped access");
    end

endmodule

// the decoder has no lanes and the data memory never sees an unmapped target.
bind mem_bus_decode arty_mem_asserts i_decode_asserts (
  .clk(clk), .reset(reset), .write_enable(write_enable), .lane_we(4'b0000),
  .dmem_write_enable(dmem_write_enable), .led_write_enable(led_write_enable),
  .target(target), .data_out(data_out));

bind d_mem_spram arty_mem_asserts i_dmem_asserts (
  .clk(clk), .reset(reset), .write_enable(write_enable), .lane_we(lane_we),
  .dmem_write_enable(1'b0), .led_write_enable(1'b0),
  .target(mem_pkg::TGT_DMEM), .data_out(data_out));

`default_nettype wire

/* verification/tb_arty_mem.sv */
// tb_arty_mem: testbench with a byte-array reference model, directed and random load/store checks
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module tb_arty_mem
  import mem_pkg::*;
();

  localparam int MEM_BYTES  = 2**`DMEM_ADDR_WIDTH;
  localparam int MAX_CYCLES = 4000; // about 2150 cycles of reset, fill and accesses.

  logic                       clk = 1'b0;
  logic                       reset = 1'b1;
  logic [`BUS_ADDR_WIDTH-1:0] addr = 16'hffff; // unmapped, so the port reads zero at first.
  mem_width_t                 width = RESERVED;
  logic                       sign_extend = 1'b0;
  logic [31:0]                data_in = '0;
  logic                       write_enable = 1'b0;
  logic [31:0]                data_out;
  logic [3:0]                 leds;

  logic [7:0]  mem_model [MEM_BYTES];
  logic [31:0] led_model = '0;
  logic        stim_valid = 1'b1; // zero is expected on both outputs through reset.
  logic [31:0] stim_expected = '0;
  logic [3:0]  stim_leds = '0;
  logic        chk_valid = 1'b0;
  logic [31:0] chk_expected;
  logic [3:0]  chk_leds;
  int          errors = 0;
  int          cycles = 0;
  int          seed = 44138;

  always #10 clk = ~clk;

  arty_mem_top i_arty_mem_top (.*);

  // byte k of an access sits at byte address addr+k, wrapping at the top of memory.
  function automatic logic [31:0] ref_load(input logic [`BUS_ADDR_WIDTH-1:0] a,
                                           input mem_width_t w, input logic s);
    logic [31:0] word;
    if (a[15]) return (a == `LED_ADDR) ? led_model : 32'd0;
    for (int k = 0; k < 4; k++) begin
      word[8*k +: 8] = mem_model[(a + k) % MEM_BYTES];
    end
    case (w)
      BYTE:     return {{24{s & word[7]}}, word[7:0]};
      HALFWORD: return {{16{s & word[15]}}, word[15:0]};
      default:  return word;
    endcase
  endfunction

  task automatic access(input logic [`BUS_ADDR_WIDTH-1:0] a, input mem_width_t w,
                        input logic s, input logic [31:0] d, input logic we, input logic check);
    int n;
    @(posedge clk);
    stim_expected <= ref_load(a, w, s); // taken before the store, as the RAMs read first.
    n = (w == BYTE) ? 1 : (w == HALFWORD) ? 2 : (w == WORD) ? 4 : 0;
    if (we && !a[15]) begin
      for (int k = 0; k < n; k++) mem_model[(a + k) % MEM_BYTES] = d[8*k +: 8];
    end
    if (we && a == `LED_ADDR && w == WORD) led_model = d;
    addr         <= a;
    width        <= w;
    sign_extend  <= s;
    data_in      <= d;
    write_enable <= we;
    stim_valid   <= check;
    stim_leds    <= led_model[3:0];
  endtask

  always @(posedge clk) begin
    chk_valid    <= stim_valid; // the response to an access is due one cycle later.
    chk_expected <= stim_expected;
    chk_leds     <= stim_leds;
    cycles       <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (chk_valid && data_out !== chk_expected) begin
      errors++;
      $display("mismatch data_out: expected %h, got %h", chk_expected, data_out);
    end
    if (chk_valid && leds !== chk_leds) begin
      errors++;
      $display("mismatch leds: expected %h, got %h", chk_leds, leds);
    end
  end

  initial begin
    logic [31:0]                r;
    logic [`BUS_ADDR_WIDTH-1:0] a;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    for (int i = 0; i < MEM_BYTES; i += 4) begin
      access(16'(i), WORD, 1'b0, {i[11:2] ^ 10'h2c7, 2'b10, ~i[11:2], i[11:2]}, 1'b1, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      access(16'h0100 + 16'(4 * (i % 8)), WORD, 1'b0, 32'hc0de_0000 + 32'(i), i < 8, 1'b1);
    end
    for (int off = 0; off < 4; off++) begin
      access(16'h0200 + 16'(off), BYTE, 1'b0, 32'h5a5a_5aa0 + 32'(off), 1'b1, 1'b1);
      access(16'h0280 + 16'(off), HALFWORD, 1'b0, 32'hffff_9ab0 + 32'(off), 1'b1, 1'b1);
      for (int i = -1; i < 2; i++) begin
        access(16'h0200 + 16'(4 * i), WORD, 1'b0, 32'd0, 1'b0, 1'b1);
        access(16'h0280 + 16'(4 * i), WORD, 1'b0, 32'd0, 1'b0, 1'b1);
      end
    end
    for (int off = 0; off < 4; off++) begin
      access(16'h0300 + 16'(off), WORD, 1'b0, 32'h80f0_7f81 ^ 32'(off), 1'b1, 1'b1);
      access(16'h0341 + 16'(off), HALFWORD, 1'b0, 32'h0000_8e71, 1'b1, 1'b1);
      for (int i = 0; i < 8; i++) begin
        access(16'h0300 + 16'(off), mem_width_t'(i[1:0]), i[2], 32'd0, 1'b0, 1'b1);
        access(16'h0341 + 16'(off), mem_width_t'(i[1:0]), i[2], 32'd0, 1'b0, 1'b1);
      end
    end
    access(16'h0ffe, WORD, 1'b0, 32'hdead_beef, 1'b1, 1'b1); // last row wraps to row 0.
    for (int i = 0; i < 4; i++) begin
      access(16'h0ffd + 16'(i), WORD, 1'b0, 32'd0, 1'b0, 1'b1);
      access(16'h1ffd + 16'(i), HALFWORD, 1'b1, 32'd0, 1'b0, 1'b1);
    end
    access(`LED_ADDR, WORD, 1'b0, 32'h1234_567b, 1'b1, 1'b1);
    access(`LED_ADDR, WORD, 1'b0, 32'd0, 1'b0, 1'b1);
    access(`LED_ADDR, BYTE, 1'b0, 32'h0000_0004, 1'b1, 1'b1);
    access(`LED_ADDR, HALFWORD, 1'b1, 32'd0, 1'b0, 1'b1);
    access(16'h8004, WORD, 1'b0, 32'hffff_ffff, 1'b1, 1'b1);
    access(16'hffff, WORD, 1'b0, 32'd0, 1'b0, 1'b1);
    repeat (1000) begin
      r = $random(seed);
      a = (r[2:0] == 3'd7) ? {1'b1, r[17:3]} : (r[2:0] == 3'd6) ? `LED_ADDR : {1'b0, r[17:3]};
      access(a, mem_width_t'(r[19:18]), r[20], $random(seed), r[21], 1'b1);
    end
    repeat (2) access(16'hffff, RESERVED, 1'b0, 32'd0, 1'b0, 1'b0);
    errors += i_arty_mem_top.i_mem_bus_decode.i_decode_asserts.failures;
    errors += i_arty_mem_top.i_d_mem_spram.i_dmem_asserts.failures;
    $display("tb_arty_mem finished with %0d errors", errors);
    if (errors == 0) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/mem_pkg.sv
src/spram_block.sv
src/d_mem_spram.sv
src/led_port.sv
src/mem_bus_decode.sv
src/arty_mem_top.sv
verification/arty_mem_asserts.sv
verification/tb_arty_mem.sv

/* Bender.yml */
package:
  name: arty_mem

sources:
  - include_dirs:
      - src
    files:
      - src/mem_pkg.sv
      - src/spram_block.sv
      - src/d_mem_spram.sv
      - src/led_port.sv
      - src/mem_bus_decode.sv
      - src/arty_mem_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verification/arty_mem_asserts.sv
      - verification/tb_arty_mem.sv
